// ==== bp_cfg.svh ====
// branch predictor sizing
`ifndef BP_CFG_SVH
`define BP_CFG_SVH

// log2 of entries per table, btb and bht share one index
`define BP_LOG_ENTRIES 10
`define BP_ENTRIES (1 << `BP_LOG_ENTRIES)

// index field of the pc, bits 1:0 are ignored
`define BP_IDX_LO 2
`define BP_IDX_HI (`BP_LOG_ENTRIES + 1)

// tag field sits just above the index
`define BP_TAG_BITS 8
`define BP_TAG_LO (`BP_LOG_ENTRIES + 2)
`define BP_TAG_HI (`BP_LOG_ENTRIES + `BP_TAG_BITS + 1)

// target word bits kept per btb entry, upper bits come from the fetch pc
`define BP_TGT_BITS (`BP_LOG_ENTRIES + `BP_TAG_BITS)

`endif

// ==== fetch_pkg.sv ====
// fetch side types
package fetch_pkg;

	// 64-bit instruction address, word aligned in use
	typedef logic [63:0] pc_t;

	// per slot lookup result
	typedef struct packed {
		logic hit;    // btb tag match with valid entry
		logic taken;  // bht counter msb
		pc_t  target; // rebuilt target address
	} slot_pred_t;

	// combined next fetch prediction
	typedef struct packed {
		logic taken; // one of the two slots redirects
		logic slot;  // which slot was predicted taken
		pc_t  npc;   // next fetch pc
	} fetch_pred_t;

endpackage

// ==== retire_pkg.sv ====
// training side types
package retire_pkg;

	// 2-bit saturating direction counter
	// 00 01 predict not taken, 10 11 predict taken
	typedef logic [1:0] ctr_t;

	localparam ctr_t CTR_RESET = 2'b01; // weakly not taken
	localparam ctr_t CTR_MAX   = 2'b11;
	localparam ctr_t CTR_MIN   = 2'b00;

	// one retired control transfer from the rob
	typedef struct packed {
		logic            valid;  // a control transfer retired this cycle
		logic            taken;  // resolved direction
		fetch_pkg::pc_t  pc;     // address of the branch
		fetch_pkg::pc_t  target; // only meaningful when taken
	} retire_upd_t;

endpackage

// ==== btb.sv ====
// branch target buffer
// tagged, direct mapped, two lookups and two retire writes
`timescale 1ns/1ns
`include "bp_cfg.svh"

module btb (
	input  logic                    clock,
	input  logic                    reset,
	input  fetch_pkg::pc_t          pc0,     // slot 0 lookup
	input  fetch_pkg::pc_t          pc1,     // slot 1 lookup
	input  retire_pkg::retire_upd_t retire0, // older retire
	input  retire_pkg::retire_upd_t retire1, // younger retire
	output logic                    hit0,
	output logic                    hit1,
	output fetch_pkg::pc_t          target0,
	output fetch_pkg::pc_t          target1
);

	// entry state
	logic [`BP_ENTRIES-1:0]  valid;
	logic [`BP_TAG_BITS-1:0] tag_mem [`BP_ENTRIES];
	logic [`BP_TGT_BITS-1:0] tgt_mem [`BP_ENTRIES];

	// lookup fields
	logic [`BP_LOG_ENTRIES-1:0] rd_idx0;
	logic [`BP_LOG_ENTRIES-1:0] rd_idx1;
	logic [`BP_TAG_BITS-1:0]    rd_tag0;
	logic [`BP_TAG_BITS-1:0]    rd_tag1;

	// write fields
	logic                       we0;
	logic                       we1;
	logic [`BP_LOG_ENTRIES-1:0] wr_idx0;
	logic [`BP_LOG_ENTRIES-1:0] wr_idx1;
	logic [`BP_TAG_BITS-1:0]    wr_tag0;
	logic [`BP_TAG_BITS-1:0]    wr_tag1;
	logic [`BP_TGT_BITS-1:0]    wr_tgt0;
	logic [`BP_TGT_BITS-1:0]    wr_tgt1;

	assign rd_idx0 = pc0[`BP_IDX_HI:`BP_IDX_LO];
	assign rd_idx1 = pc1[`BP_IDX_HI:`BP_IDX_LO];
	assign rd_tag0 = pc0[`BP_TAG_HI:`BP_TAG_LO];
	assign rd_tag1 = pc1[`BP_TAG_HI:`BP_TAG_LO];

	// hit needs both a live entry and a matching tag
	assign hit0 = valid[rd_idx0] && (tag_mem[rd_idx0] == rd_tag0);
	assign hit1 = valid[rd_idx1] && (tag_mem[rd_idx1] == rd_tag1);

	// upper bits borrowed from the looked up pc, far targets mispredict
	assign target0 = {pc0[63:`BP_TGT_BITS+2], tgt_mem[rd_idx0], 2'b00};
	assign target1 = {pc1[63:`BP_TGT_BITS+2], tgt_mem[rd_idx1], 2'b00};

	// only taken transfers allocate
	assign we0 = retire0.valid && retire0.taken;
	assign we1 = retire1.valid && retire1.taken;

	assign wr_idx0 = retire0.pc[`BP_IDX_HI:`BP_IDX_LO];
	assign wr_idx1 = retire1.pc[`BP_IDX_HI:`BP_IDX_LO];
	assign wr_tag0 = retire0.pc[`BP_TAG_HI:`BP_TAG_LO];
	assign wr_tag1 = retire1.pc[`BP_TAG_HI:`BP_TAG_LO];
	assign wr_tgt0 = retire0.target[`BP_TGT_BITS+1:2]; // word bits of the target
	assign wr_tgt1 = retire1.target[`BP_TGT_BITS+1:2];

	// valid bits, cleared by reset
	always_ff @(posedge clock) begin
		if (reset) begin
			valid <= '0;
		end else begin
			if (we0)
				valid[wr_idx0] <= 1'b1;
			if (we1)
				valid[wr_idx1] <= 1'b1;
		end
	end

	// tag and target payload
	// retire1 is younger so its write lands last on a shared entry
	always_ff @(posedge clock) begin
		if (we0) begin
			tag_mem[wr_idx0] <= wr_tag0;
			tgt_mem[wr_idx0] <= wr_tgt0;
		end
		if (we1) begin
			tag_mem[wr_idx1] <= wr_tag1;
			tgt_mem[wr_idx1] <= wr_tgt1;
		end
	end

endmodule

// ==== bht.sv ====
// branch history table
// untagged 2-bit counters, dual retire training
`timescale 1ns/1ns
`include "bp_cfg.svh"

module bht (
	input  logic                    clock,
	input  logic                    reset,
	input  fetch_pkg::pc_t          pc0,     // slot 0 lookup
	input  fetch_pkg::pc_t          pc1,     // slot 1 lookup
	input  retire_pkg::retire_upd_t retire0, // older retire
	input  retire_pkg::retire_upd_t retire1, // younger retire
	output logic                    taken0,
	output logic                    taken1
);

	import retire_pkg::*;

	ctr_t ctr_mem [`BP_ENTRIES];

	logic [`BP_LOG_ENTRIES-1:0] rd_idx0;
	logic [`BP_LOG_ENTRIES-1:0] rd_idx1;
	logic [`BP_LOG_ENTRIES-1:0] wr_idx0;
	logic [`BP_LOG_ENTRIES-1:0] wr_idx1;
	logic                       same_idx; // both retires land on one counter
	ctr_t                       next0;
	ctr_t                       next1;

	// one saturating step
	function automatic ctr_t ctr_step(input ctr_t c, input logic taken);
		ctr_t n;
		n = c;
		if (taken && c != CTR_MAX)
			n = c + 2'd1;
		else if (!taken && c != CTR_MIN)
			n = c - 2'd1;
		return n;
	endfunction

	assign rd_idx0 = pc0[`BP_IDX_HI:`BP_IDX_LO];
	assign rd_idx1 = pc1[`BP_IDX_HI:`BP_IDX_LO];
	assign wr_idx0 = retire0.pc[`BP_IDX_HI:`BP_IDX_LO];
	assign wr_idx1 = retire1.pc[`BP_IDX_HI:`BP_IDX_LO];

	// msb is the direction
	assign taken0 = ctr_mem[rd_idx0][1];
	assign taken1 = ctr_mem[rd_idx1][1];

	assign same_idx = retire0.valid && (wr_idx0 == wr_idx1);

	always_comb begin
		next0 = ctr_step(ctr_mem[wr_idx0], retire0.taken);
		// chain onto retire0's result so both steps count
		if (same_idx)
			next1 = ctr_step(next0, retire1.taken);
		else
			next1 = ctr_step(ctr_mem[wr_idx1], retire1.taken);
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			for (int i = 0; i < `BP_ENTRIES; i++)
				ctr_mem[i] <= CTR_RESET; // weakly not taken
		end else begin
			if (retire0.valid)
				ctr_mem[wr_idx0] <= next0;
			if (retire1.valid)
				ctr_mem[wr_idx1] <= next1; // already holds both steps when shared
		end
	end

endmodule

// ==== next_pc_select.sv ====
// next fetch pc selection
`timescale 1ns/1ns

module next_pc_select (
	input  fetch_pkg::pc_t         pc,    // fetch pc of slot 0
	input  fetch_pkg::slot_pred_t  slot0,
	input  fetch_pkg::slot_pred_t  slot1,
	output fetch_pkg::fetch_pred_t pred
);

	import fetch_pkg::*;

	pc_t  seq_pc; // fall through past both slots
	logic redir0;
	logic redir1;

	// byte offset inside the word is ignored
	assign seq_pc = {pc[63:2], 2'b00} + 64'd8;

	// a slot redirects only when the btb knows it and the counter says taken
	assign redir0 = slot0.hit && slot0.taken;
	assign redir1 = slot1.hit && slot1.taken;

	always_comb begin
		pred.taken = 1'b0;
		pred.slot  = 1'b0;
		pred.npc   = seq_pc;
		if (redir0) begin
			// older slot wins
			pred.taken = 1'b1;
			pred.slot  = 1'b0;
			pred.npc   = slot0.target;
		end else if (redir1) begin
			pred.taken = 1'b1;
			pred.slot  = 1'b1;
			pred.npc   = slot1.target;
		end
	end

endmodule

// ==== fetch_predictor.sv ====
// two wide fetch branch predictor
`timescale 1ns/1ns

module fetch_predictor (
	input  logic                    clock,
	input  logic                    reset,
	input  fetch_pkg::pc_t          fetch_pc,
	input  retire_pkg::retire_upd_t retire0, // older
	input  retire_pkg::retire_upd_t retire1, // younger
	output fetch_pkg::fetch_pred_t  pred
);

	import fetch_pkg::*;

	pc_t        pc_plus4; // slot 1 address
	slot_pred_t slot0;
	slot_pred_t slot1;

	assign pc_plus4 = fetch_pc + 64'd4;

	btb btb_i (
		.clock   (clock),
		.reset   (reset),
		.pc0     (fetch_pc),
		.pc1     (pc_plus4),
		.retire0 (retire0),
		.retire1 (retire1),
		.hit0    (slot0.hit),
		.hit1    (slot1.hit),
		.target0 (slot0.target),
		.target1 (slot1.target)
	);

	bht bht_i (
		.clock   (clock),
		.reset   (reset),
		.pc0     (fetch_pc),
		.pc1     (pc_plus4),
		.retire0 (retire0),
		.retire1 (retire1),
		.taken0  (slot0.taken),
		.taken1  (slot1.taken)
	);

	next_pc_select select_i (
		.pc    (fetch_pc),
		.slot0 (slot0),
		.slot1 (slot1),
		.pred  (pred)
	);

endmodule

// ==== fetch_predictor_sva.sv ====
// prediction output assertions
`timescale 1ns/1ns

module fetch_predictor_sva (
	input logic                   clock,
	input logic                   reset,
	input fetch_pkg::pc_t         fetch_pc,
	input fetch_pkg::fetch_pred_t pred
);

	import fetch_pkg::*;

	pc_t seq_pc; // fall through past both slots

	assign seq_pc = {fetch_pc[63:2], 2'b00} + 64'd8;

	// targets and fall through are always whole words
	npc_aligned: assert property (@(posedge clock) disable iff (reset)
		pred.npc[1:0] == 2'b00)
		else $error("npc is not word aligned");

	// freshly reset tables cannot redirect
	quiet_after_reset: assert property (@(posedge clock)
		$fell(reset) |-> !pred.taken)
		else $error("taken prediction right after reset");

	// sequential npc means no slot redirected
	seq_not_taken: assert property (@(posedge clock) disable iff (reset)
		(pred.npc == seq_pc) |-> !pred.taken)
		else $error("taken asserted with sequential npc");

endmodule

bind fetch_predictor fetch_predictor_sva sva_i (
	.clock    (clock),
	.reset    (reset),
	.fetch_pc (fetch_pc),
	.pred     (pred)
);

// ==== fetch_predictor_tb.sv ====
// fetch predictor testbench
`timescale 1ns/1ns
`include "bp_cfg.svh"

module fetch_predictor_tb;

	import fetch_pkg::*;
	import retire_pkg::*;

	typedef logic [`BP_LOG_ENTRIES-1:0] idx_t;

	localparam int CLK_PERIOD    = 40;
	localparam int TEST_CYCLES   = 40; // all tests plus reset, with some slack
	localparam int MARGIN_CYCLES = 20;
	localparam int WATCHDOG_NS   = (TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;

	logic        clock;
	logic        reset;
	pc_t         fetch_pc;
	retire_upd_t retire0;
	retire_upd_t retire1;
	fetch_pred_t pred;

	integer seed;
	int     errors;
	int     err_mark;     // error count at test start
	int     tests_run;
	int     tests_failed;
	string  cur_test;

	// expected table contents
	logic                    model_valid [`BP_ENTRIES];
	logic [`BP_TAG_BITS-1:0] model_tag   [`BP_ENTRIES];
	logic [`BP_TGT_BITS-1:0] model_tgt   [`BP_ENTRIES];
	ctr_t                    model_ctr   [`BP_ENTRIES];

	fetch_predictor dut_i (
		.clock    (clock),
		.reset    (reset),
		.fetch_pc (fetch_pc),
		.retire0  (retire0),
		.retire1  (retire1),
		.pred     (pred)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	task automatic check_pc(string name, pc_t exp, pc_t got);
		if (got !== exp) begin
			errors++;
			$display("ERR %0s exp %h got %h", name, exp, got);
		end
	endtask

	task automatic check_bit(string name, logic exp, logic got);
		if (got !== exp) begin
			errors++;
			$display("ERR %0s exp %h got %h", name, exp, got);
		end
	endtask

	// saturating counter step
	function automatic ctr_t counter_next(ctr_t c, logic taken);
		if (taken)
			return (c == 2'b11) ? c : c + 2'b01;
		return (c == 2'b00) ? c : c - 2'b01;
	endfunction

	function automatic void model_train(retire_upd_t r);
		idx_t i;
		i = r.pc[`BP_IDX_HI:`BP_IDX_LO];
		if (r.valid) begin
			model_ctr[i] = counter_next(model_ctr[i], r.taken);
			if (r.taken) begin // btb allocates on taken only
				model_valid[i] = 1'b1;
				model_tag[i]   = r.pc[`BP_TAG_HI:`BP_TAG_LO];
				model_tgt[i]   = r.target[`BP_TGT_BITS+1:2];
			end
		end
	endfunction

	function automatic slot_pred_t model_lookup(pc_t pc);
		slot_pred_t s;
		idx_t       i;
		i        = pc[`BP_IDX_HI:`BP_IDX_LO];
		s.hit    = model_valid[i] && (model_tag[i] == pc[`BP_TAG_HI:`BP_TAG_LO]);
		s.taken  = model_ctr[i][1];
		s.target = {pc[63:`BP_TGT_BITS+2], model_tgt[i], 2'b00}; // upper bits from pc
		return s;
	endfunction

	// selection rule, slot 0 first
	function automatic fetch_pred_t expected_pred(pc_t pc);
		slot_pred_t  s0;
		slot_pred_t  s1;
		fetch_pred_t p;
		s0      = model_lookup(pc);
		s1      = model_lookup(pc + 64'd4);
		p.taken = 1'b0;
		p.slot  = 1'b0;
		p.npc   = {pc[63:2], 2'b00} + 64'd8; // odd offsets fall back to the word
		if (s0.hit && s0.taken) begin
			p.taken = 1'b1;
			p.npc   = s0.target;
		end else if (s1.hit && s1.taken) begin
			p.taken = 1'b1;
			p.slot  = 1'b1;
			p.npc   = s1.target;
		end
		return p;
	endfunction

	function automatic retire_upd_t make_retire(pc_t pc, logic taken, pc_t target);
		retire_upd_t r;
		r.valid  = 1'b1;
		r.taken  = taken;
		r.pc     = pc;
		r.target = target;
		return r;
	endfunction

	function automatic pc_t rand_pc();
		pc_t p;
		p      = {$random(seed), $random(seed)};
		p[1:0] = 2'b00; // word aligned
		return p;
	endfunction

	// forward target well away from pc+8
	function automatic pc_t rand_target(pc_t pc);
		logic [31:0] off;
		off = $random(seed);
		return pc + 64'h100 + {52'd0, off[9:0], 2'b00};
	endfunction

	// one retire cycle, then the ports go idle
	task automatic apply_retires(retire_upd_t r0, retire_upd_t r1);
		retire0 = r0;
		retire1 = r1;
		model_train(r0);
		model_train(r1); // younger one lands last
		@(posedge clock);
		#2;
		retire0 = '0;
		retire1 = '0;
	endtask

	// npc from the model, direction and slot as the test expects
	task automatic check_fetch(pc_t pc, logic exp_taken, logic exp_slot);
		fetch_pred_t exp;
		fetch_pc = pc;
		#1; // combinational settle
		exp = expected_pred(pc);
		check_bit("model.taken", exp_taken, exp.taken);
		check_bit("pred.taken", exp_taken, pred.taken);
		check_bit("pred.slot", exp_slot, pred.slot);
		check_pc("pred.npc", exp.npc, pred.npc);
		@(posedge clock);
		#2;
	endtask

	task automatic start_test(string name);
		cur_test = name;
		err_mark = errors;
	endtask

	task automatic finish_test();
		tests_run++;
		if (errors != err_mark) begin
			tests_failed++;
			$display("test %0s: %0d mismatches", cur_test, errors - err_mark);
		end else begin
			$display("test %0s: ok", cur_test);
		end
	endtask

	task automatic idle_fall_through();
		pc_t         pc;
		logic [31:0] r;
		start_test("idle_fall_through");
		repeat (6) begin
			pc      = rand_pc();
			r       = $random(seed);
			pc[1:0] = r[1:0]; // byte offset inside the word is ignored
			check_fetch(pc, 1'b0, 1'b0);
		end
		finish_test();
	endtask

	task automatic single_taken_train();
		pc_t pc;
		pc = rand_pc();
		start_test("single_taken_train");
		apply_retires(make_retire(pc, 1'b1, rand_target(pc)), '0); // 01 -> 10
		check_fetch(pc, 1'b1, 1'b0);
		finish_test();
	endtask

	task automatic slot_priority();
		pc_t pc;
		pc = rand_pc();
		start_test("slot_priority");
		apply_retires(make_retire(pc + 64'd4, 1'b1, rand_target(pc + 64'd4)), '0);
		check_fetch(pc, 1'b1, 1'b1); // slot 1 alone
		apply_retires(make_retire(pc, 1'b1, rand_target(pc)), '0);
		check_fetch(pc, 1'b1, 1'b0); // older slot takes over
		finish_test();
	endtask

	task automatic counter_hysteresis();
		pc_t pc;
		pc_t tgt;
		pc  = rand_pc();
		tgt = rand_target(pc);
		start_test("counter_hysteresis");
		apply_retires(make_retire(pc, 1'b1, tgt), '0);
		apply_retires(make_retire(pc, 1'b1, tgt), '0); // now 11
		check_fetch(pc, 1'b1, 1'b0);
		apply_retires(make_retire(pc, 1'b0, tgt), '0);
		check_fetch(pc, 1'b1, 1'b0); // 10 still taken
		apply_retires(make_retire(pc, 1'b0, tgt), '0);
		check_fetch(pc, 1'b0, 1'b0);
		finish_test();
	endtask

	task automatic tag_mismatch();
		pc_t pc;
		pc_t alias_pc;
		pc       = rand_pc();
		alias_pc = pc ^ (64'd1 << `BP_TAG_LO); // same index, other tag
		start_test("tag_mismatch");
		apply_retires(make_retire(pc, 1'b1, rand_target(pc)), '0);
		check_fetch(pc, 1'b1, 1'b0);
		check_fetch(alias_pc, 1'b0, 1'b0); // shared counter is taken but btb misses
		finish_test();
	endtask

	task automatic dual_retire_same_entry();
		pc_t pc;
		pc_t tgt;
		pc = rand_pc();
		start_test("dual_retire_same_entry");
		apply_retires(make_retire(pc, 1'b1, rand_target(pc)), '0); // 10
		apply_retires(make_retire(pc, 1'b1, rand_target(pc)),
			make_retire(pc, 1'b0, rand_target(pc)));
		check_fetch(pc, 1'b1, 1'b0); // chained steps cancel
		tgt = rand_target(pc);
		apply_retires(make_retire(pc, 1'b1, tgt),
			make_retire(pc, 1'b1, tgt + 64'h40)); // stored bits differ
		check_fetch(pc, 1'b1, 1'b0); // younger target expected
		finish_test();
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("timeout, tests did not finish within %0d ns", WATCHDOG_NS);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		seed         = 93;
		errors       = 0;
		err_mark     = 0;
		tests_run    = 0;
		tests_failed = 0;
		reset        = 1'b1;
		fetch_pc     = '0;
		retire0      = '0;
		retire1      = '0;
		model_valid  = '{default: 1'b0};
		model_tag    = '{default: '0};
		model_tgt    = '{default: '0};
		model_ctr    = '{default: 2'b01}; // weakly not taken
		repeat (2) @(posedge clock);
		#2;
		reset = 1'b0;
		idle_fall_through();
		single_taken_train();
		slot_priority();
		counter_hysteresis();
		tag_mismatch();
		dual_retire_same_entry();
		$display("%0d tests run, %0d failed, %0d mismatches", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== tb.f ====
+incdir+.
fetch_pkg.sv
retire_pkg.sv
btb.sv
bht.sv
next_pc_select.sv
fetch_predictor.sv
fetch_predictor_sva.sv
fetch_predictor_tb.sv

// ==== run.sh ====
#!/bin/bash
# build and run the fetch predictor testbench with verilator

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert -j 0 \
	--top-module fetch_predictor_tb \
	-f tb.f \
	-Mdir obj_dir -o fetch_predictor_sim > build.log 2>&1 \
	&& ./obj_dir/fetch_predictor_sim > sim.log 2>&1 \
	|| { cat build.log sim.log 2>/dev/null; echo "build or simulation did not complete"; exit 1; }

cat sim.log
grep -q "Testbench passed" sim.log && exit 0 || exit 1
